// ==== logic/fhbuf_pkg.sv ====
package fhbuf_pkg;

        // one complex sample
        // i in bits 31:16, q in bits 15:0
        typedef logic [31:0] iq_sample_t;

        // sideband user/symbol tag
        // travels with every sample on the stream
        typedef logic [1:0] user_id_t;

        // one beat on any stream port
        // valid is a plain strobe with no ready behind it
        typedef struct packed {
                logic       valid;
                user_id_t   user;
                iq_sample_t data;
        } iq_beat_t;

        // stored wave buffer entry
        // valid is not stored, it comes from the read strobe
        typedef struct packed {
                user_id_t   user;
                iq_sample_t data;
        } wave_word_t;

        // playback controller states
        // idle       test mode off
        // wait_frame armed, waiting for the downlink frame marker
        // run        reading the buffer on each sample enable
        typedef enum logic [1:0] {
                PLAY_IDLE       = 2'd0,
                PLAY_WAIT_FRAME = 2'd1,
                PLAY_RUN        = 2'd2
        } play_state_t;

        // 2'd3 is not used
        // the fsm falls back to idle from it

endpackage

// ==== logic/wave_buffer.sv ====
module wave_buffer #(
        parameter int BUF_DEPTH = 64
) (
        input  logic                           clk_1x,
        input  logic                           rst_n,
        // load port, same clock as playback
        input  logic                           load_en,
        input  logic [$clog2(BUF_DEPTH)-1:0]   load_addr,
        input  fhbuf_pkg::wave_word_t          load_word,
        // playback read port
        input  logic                           rd_en,
        input  logic [$clog2(BUF_DEPTH)-1:0]   rd_addr,
        output fhbuf_pkg::iq_beat_t            play_beat
);

        import fhbuf_pkg::*;

        // test waveform storage
        wave_word_t mem [BUF_DEPTH];

        // registered read word
        wave_word_t rd_word;

        // rd_en delayed by one cycle
        logic rd_vld;

        // single clocked block for write and read
        // a read of the address being loaded sees the old word
        // since both updates are nonblocking
        always_ff @(posedge clk_1x) begin
                if (load_en) begin
                        mem[load_addr] <= load_word;
                end
                // hold last word when not reading
                if (rd_en) begin
                        rd_word <= mem[rd_addr];
                end
        end

        // valid tracks the read strobe
        always_ff @(posedge clk_1x or negedge rst_n) begin
                if (!rst_n) begin
                        rd_vld <= 1'b0;
                end else begin
                        rd_vld <= rd_en;
                end
        end

        // beat is out one cycle after rd_en
        assign play_beat = '{
                valid: rd_vld,
                user:  rd_word.user,
                data:  rd_word.data
        };

endmodule

// ==== logic/play_counter.sv ====
module play_counter #(
        parameter int BUF_DEPTH = 64
) (
        input  logic                           clk_1x,
        input  logic                           rst_n,
        input  logic                           restart,
        input  logic                           rd_en,
        // one bit wider than the address, so BUF_DEPTH itself fits
        input  logic [$clog2(BUF_DEPTH):0]     play_len,
        output logic [$clog2(BUF_DEPTH)-1:0]   rd_addr,
        output logic                           wrap
);

        localparam int ADDR_W = $clog2(BUF_DEPTH);
        localparam int LEN_W  = ADDR_W + 1;

        // length actually used for the loop
        logic [LEN_W-1:0] eff_len;
        logic [LEN_W-1:0] last_addr;
        logic             at_last;
        logic [ADDR_W-1:0] addr_q;

        // zero or oversized length means the whole buffer
        always_comb begin
                if (play_len == '0 || play_len > LEN_W'(BUF_DEPTH)) begin
                        eff_len = LEN_W'(BUF_DEPTH);
                end else begin
                        eff_len = play_len;
                end
        end

        assign last_addr = eff_len - LEN_W'(1);

        // current read is the final word of the loop
        assign at_last = ({1'b0, addr_q} == last_addr);

        // restart wins over an advance in the same cycle
        // wrap is high for one cycle, when the address is back at 0
        always_ff @(posedge clk_1x or negedge rst_n) begin
                if (!rst_n) begin
                        addr_q <= '0;
                        wrap   <= 1'b0;
                end else begin
                        wrap <= 1'b0;
                        if (restart) begin
                                addr_q <= '0;
                        end else if (rd_en) begin
                                if (at_last) begin
                                        addr_q <= '0;
                                        wrap   <= 1'b1;
                                end else begin
                                        addr_q <= addr_q + 1'b1;
                                end
                        end
                end
        end

        assign rd_addr = addr_q;

endmodule

// ==== logic/play_fsm.sv ====
module play_fsm (
        input  logic clk_1x,
        input  logic rst_n,
        // sample-rate enable, one read per strobe
        input  logic clk_x1en,
        // downlink frame marker, single cycle
        input  logic frm_mrkr,
        input  logic test_mode_en,
        output logic rd_en,
        output logic restart,
        output logic running
);

        import fhbuf_pkg::*;

        play_state_t state_q;
        play_state_t state_d;

        // armed or running with test mode still on
        logic in_play;

        // next state
        // dropping test mode always goes straight back to idle
        always_comb begin
                state_d = state_q;
                case (state_q)
                        PLAY_IDLE: begin
                                if (test_mode_en) begin
                                        state_d = PLAY_WAIT_FRAME;
                                end
                        end
                        PLAY_WAIT_FRAME: begin
                                if (!test_mode_en) begin
                                        state_d = PLAY_IDLE;
                                end else if (frm_mrkr) begin
                                        state_d = PLAY_RUN;
                                end
                        end
                        PLAY_RUN: begin
                                // marker here only restarts the counter
                                if (!test_mode_en) begin
                                        state_d = PLAY_IDLE;
                                end
                        end
                        default: begin
                                state_d = PLAY_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk_1x or negedge rst_n) begin
                if (!rst_n) begin
                        state_q <= PLAY_IDLE;
                end else begin
                        state_q <= state_d;
                end
        end

        assign in_play = test_mode_en && (state_q != PLAY_IDLE);

        // frame alignment
        // counter goes to 0 at the edge after the marker,
        // both on first arm and mid-sequence
        assign restart = in_play && frm_mrkr;

        assign running = (state_q == PLAY_RUN);

        // one read per sample enable while running
        // no new reads once test mode is cleared
        assign rd_en = running && test_mode_en && clk_x1en;

endmodule

// ==== logic/path_select.sv ====
module path_select #(
        parameter int N_ANTS_SEL = 2,
        parameter int N_CARRIERS = 2
) (
        input  logic                clk_1x,
        input  logic                rst_n,
        // debug override, external stream to every output
        input  logic                bypass_sel,
        input  logic                test_mode_en,
        // playback controller in run state
        input  logic                running,
        input  fhbuf_pkg::iq_beat_t play_beat,
        input  fhbuf_pkg::iq_beat_t ext_beat,
        input  fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] dfe_in,
        output fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] pre_dfe_out,
        output fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0] test_data
);

        import fhbuf_pkg::*;

        // playback owns the outputs, shared by all streams
        logic play_sel;

        assign play_sel = test_mode_en && running;

        for (genvar a = 0; a < N_ANTS_SEL; a++) begin : g_ant
                for (genvar c = 0; c < N_CARRIERS; c++) begin : g_car
                        iq_beat_t   sel_beat;
                        logic       out_vld;
                        user_id_t   out_user;
                        iq_sample_t out_data;

                        // priority: bypass, then playback, then own input
                        always_comb begin
                                if (bypass_sel) begin
                                        sel_beat = ext_beat;
                                end else if (play_sel) begin
                                        sel_beat = play_beat;
                                end else begin
                                        sel_beat = dfe_in[a][c];
                                end
                        end

                        // valid only, so outputs are quiet out of reset
                        always_ff @(posedge clk_1x or negedge rst_n) begin
                                if (!rst_n) begin
                                        out_vld <= 1'b0;
                                end else begin
                                        out_vld <= sel_beat.valid;
                                end
                        end

                        // sample payload
                        always_ff @(posedge clk_1x) begin
                                out_user <= sel_beat.user;
                                out_data <= sel_beat.data;
                        end

                        assign pre_dfe_out[a][c] = '{
                                valid: out_vld,
                                user:  out_user,
                                data:  out_data
                        };
                end : g_car
        end : g_ant

        // per-antenna copy of the playback stream
        // independent of the source select
        for (genvar a = 0; a < N_ANTS_SEL; a++) begin : g_tst
                logic     td_vld;
                wave_word_t td_word;

                always_ff @(posedge clk_1x or negedge rst_n) begin
                        if (!rst_n) begin
                                td_vld <= 1'b0;
                        end else begin
                                td_vld <= play_beat.valid;
                        end
                end

                always_ff @(posedge clk_1x) begin
                        td_word <= '{user: play_beat.user, data: play_beat.data};
                end

                assign test_data[a] = {td_vld, td_word};
        end : g_tst

endmodule

// ==== logic/fhbuf_top.sv ====
module fhbuf_top #(
        parameter int N_ANTS_SEL = 2,
        parameter int N_CARRIERS = 2,
        parameter int BUF_DEPTH  = 64
) (
        input  logic                           clk_1x,
        input  logic                           rst_n,
        // sample-rate enable
        input  logic                           clk_x1en,
        // downlink frame marker pulse
        input  logic                           frm_mrkr,
        // test control levels
        input  logic                           bypass_sel,
        input  logic                           test_mode_en,
        input  logic [$clog2(BUF_DEPTH):0]     play_len,
        // wave buffer load port
        input  logic                           load_en,
        input  logic [$clog2(BUF_DEPTH)-1:0]   load_addr,
        input  fhbuf_pkg::wave_word_t          load_word,
        // external debug stream
        input  fhbuf_pkg::iq_beat_t            ext_beat,
        // deframer side, one beat per antenna and carrier
        input  fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] dfe_in,
        // dfe side
        output fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] pre_dfe_out,
        output fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0] test_data
);

        import fhbuf_pkg::*;

        localparam int ADDR_W = $clog2(BUF_DEPTH);

        // controller to counter and buffer
        logic rd_en;
        logic restart;
        logic running;

        // counter outputs
        logic [ADDR_W-1:0] rd_addr;
        // loop boundary marker, left for probing
        logic              wrap;

        // buffer read data, one cycle after rd_en
        iq_beat_t play_beat;

        // arm, frame alignment, read strobe
        play_fsm u_play_fsm (
                .clk_1x       (clk_1x),
                .rst_n        (rst_n),
                .clk_x1en     (clk_x1en),
                .frm_mrkr     (frm_mrkr),
                .test_mode_en (test_mode_en),
                .rd_en        (rd_en),
                .restart      (restart),
                .running      (running)
        );

        play_counter #(
                .BUF_DEPTH (BUF_DEPTH)
        ) u_play_counter (
                .clk_1x   (clk_1x),
                .rst_n    (rst_n),
                .restart  (restart),
                .rd_en    (rd_en),
                .play_len (play_len),
                .rd_addr  (rd_addr),
                .wrap     (wrap)
        );

        wave_buffer #(
                .BUF_DEPTH (BUF_DEPTH)
        ) u_wave_buffer (
                .clk_1x    (clk_1x),
                .rst_n     (rst_n),
                .load_en   (load_en),
                .load_addr (load_addr),
                .load_word (load_word),
                .rd_en     (rd_en),
                .rd_addr   (rd_addr),
                .play_beat (play_beat)
        );

        // output registers and test-data copy
        path_select #(
                .N_ANTS_SEL (N_ANTS_SEL),
                .N_CARRIERS (N_CARRIERS)
        ) u_path_select (
                .clk_1x       (clk_1x),
                .rst_n        (rst_n),
                .bypass_sel   (bypass_sel),
                .test_mode_en (test_mode_en),
                .running      (running),
                .play_beat    (play_beat),
                .ext_beat     (ext_beat),
                .dfe_in       (dfe_in),
                .pre_dfe_out  (pre_dfe_out),
                .test_data    (test_data)
        );

endmodule

// ==== tests/fhbuf_properties.sv ====
module fhbuf_properties #(
        parameter int N_ANTS_SEL = 2,
        parameter int N_CARRIERS = 2
) (
        input logic                clk_1x,
        input logic                rst_n,
        input logic                frm_mrkr,
        input logic                test_mode_en,
        input logic                rd_en,
        input logic                running,
        input fhbuf_pkg::iq_beat_t play_beat,
        input fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] pre_dfe_out,
        input fhbuf_pkg::iq_beat_t [N_ANTS_SEL-1:0] test_data
);
        timeunit 1ns;
        timeprecision 1ps;

        import fhbuf_pkg::*;

        logic [N_ANTS_SEL*N_CARRIERS-1:0] out_vld;
        logic [N_ANTS_SEL-1:0]            td_vld;
        logic                             pb_vld;

        assign pb_vld = play_beat.valid;

        // flatten the valid bits
        for (genvar a = 0; a < N_ANTS_SEL; a++) begin : g_ant
                assign td_vld[a] = test_data[a].valid;
                for (genvar c = 0; c < N_CARRIERS; c++) begin : g_car
                        assign out_vld[a*N_CARRIERS+c] = pre_dfe_out[a][c].valid;
                end
        end

        // outputs quiet while reset is held
        a_quiet_in_reset: assert property (@(posedge clk_1x) !rst_n |-> !(|out_vld || |td_vld))
                else $error("output valid high while rst_n is low");

        // test data copy is play_beat one register later, on every antenna
        a_td_follows_play: assert property (@(posedge clk_1x) disable iff (!rst_n)
                (&td_vld == $past(pb_vld)) && (|td_vld == $past(pb_vld)))
                else $error("test_data valid differs from delayed play_beat valid");

        // reads only in the run state
        // run is entered on a marker and held while test mode stays on
        a_rd_in_run: assert property (@(posedge clk_1x) disable iff (!rst_n)
                rd_en |-> running && $past(test_mode_en && (running || frm_mrkr)))
                else $error("rd_en high outside the run state");

endmodule

bind fhbuf_top fhbuf_properties #(
        .N_ANTS_SEL (N_ANTS_SEL),
        .N_CARRIERS (N_CARRIERS)
) u_properties (
        .clk_1x       (clk_1x),
        .rst_n        (rst_n),
        .frm_mrkr     (frm_mrkr),
        .test_mode_en (test_mode_en),
        .rd_en        (rd_en),
        .running      (running),
        .play_beat    (play_beat),
        .pre_dfe_out  (pre_dfe_out),
        .test_data    (test_data)
);

// ==== tests/fhbuf_tb.sv ====
module fhbuf_tb;
        timeunit 1ns;
        timeprecision 1ps;

        import fhbuf_pkg::*;

        localparam int N_ANTS_SEL = 2;
        localparam int N_CARRIERS = 2;
        localparam int BUF_DEPTH  = 64;
        localparam int ADDR_W     = $clog2(BUF_DEPTH);
        localparam int LEN_W      = ADDR_W + 1;
        localparam int N_ROWS     = 11;
        localparam int NO_FRM     = 255;

        // one scenario per row
        typedef struct packed {
                logic             bypass_sel;
                logic             test_mode_en;
                logic [LEN_W-1:0] play_len;
                logic [7:0]       cycles;
                // x1en every fourth cycle instead of every cycle
                logic             x1en_quarter;
                // row cycle with the frame marker, NO_FRM for none
                logic [7:0]       frm_at;
        } row_t;

        logic              clk_1x;
        logic              rst_n;
        logic              clk_x1en;
        logic              frm_mrkr;
        logic              bypass_sel;
        logic              test_mode_en;
        logic [LEN_W-1:0]  play_len;
        logic              load_en;
        logic [ADDR_W-1:0] load_addr;
        wave_word_t        load_word;
        iq_beat_t          ext_beat;
        iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] dfe_in;
        iq_beat_t [N_ANTS_SEL-1:0][N_CARRIERS-1:0] pre_dfe_out;
        iq_beat_t [N_ANTS_SEL-1:0] test_data;

        row_t   rows [N_ROWS];
        integer seed = 16463;
        int     cycle_cnt = 0;
        int     cycle_limit = 200;
        int     n_checks = 0;

        // reference model state
        wave_word_t  ref_mem [BUF_DEPTH];
        play_state_t mdl_state;
        int          mdl_addr;
        // model of the buffer read beat
        iq_beat_t    mdl_play;
        // expected outputs after the next edge
        iq_beat_t    exp_out [N_ANTS_SEL][N_CARRIERS];
        logic        exp_full [N_ANTS_SEL][N_CARRIERS];
        iq_beat_t    exp_td [N_ANTS_SEL];
        // expected loop boundary pulse from the counter
        logic        exp_wrap;

        fhbuf_top #(
                .N_ANTS_SEL (N_ANTS_SEL),
                .N_CARRIERS (N_CARRIERS),
                .BUF_DEPTH  (BUF_DEPTH)
        ) dut (.*);

        always #20 clk_1x = ~clk_1x;

        // run limit from the table length
        always @(posedge clk_1x) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= cycle_limit) begin
                        $display("timeout: %0d cycles passed and the table did not finish",
                                cycle_limit);
                        $display("tests failed");
                        $fatal(1, "stopped by the cycle limit");
                end
        end

        task automatic check_value(input string name, input logic [63:0] got,
                        input logic [63:0] expected);
                n_checks++;
                if (got !== expected) begin
                        $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
                        $display("tests failed");
                        $fatal(1, "value mismatch at %0t", $time);
                end
        endtask

        task automatic check_outputs();
                int a;
                int c;
                for (a = 0; a < N_ANTS_SEL; a++) begin
                        for (c = 0; c < N_CARRIERS; c++) begin
                                check_value($sformatf("pre_dfe_out[%0d][%0d].valid", a, c),
                                        64'(pre_dfe_out[a][c].valid), 64'(exp_out[a][c].valid));
                                // idle playback payload is a don't care
                                if (exp_full[a][c] || exp_out[a][c].valid) begin
                                        check_value($sformatf("pre_dfe_out[%0d][%0d].user", a, c),
                                                64'(pre_dfe_out[a][c].user), 64'(exp_out[a][c].user));
                                        check_value($sformatf("pre_dfe_out[%0d][%0d].data", a, c),
                                                64'(pre_dfe_out[a][c].data), 64'(exp_out[a][c].data));
                                end
                        end
                        check_value($sformatf("test_data[%0d].valid", a),
                                64'(test_data[a].valid), 64'(exp_td[a].valid));
                        if (exp_td[a].valid) begin
                                check_value($sformatf("test_data[%0d].user", a),
                                        64'(test_data[a].user), 64'(exp_td[a].user));
                                check_value($sformatf("test_data[%0d].data", a),
                                        64'(test_data[a].data), 64'(exp_td[a].data));
                        end
                end
                // loop boundary seen inside the top level
                check_value("wrap", 64'(dut.wrap), 64'(exp_wrap));
        endtask

        // expected response to the inputs now on the pins
        task automatic model_update();
                int   a;
                int   c;
                int   len_i;
                logic run_now;
                logic rd_now;
                logic restart_now;
                run_now     = (mdl_state == PLAY_RUN);
                rd_now      = run_now && test_mode_en && clk_x1en;
                restart_now = test_mode_en && (mdl_state != PLAY_IDLE) && frm_mrkr;
                // source priority, bypass over playback over own input
                for (a = 0; a < N_ANTS_SEL; a++) begin
                        for (c = 0; c < N_CARRIERS; c++) begin
                                exp_full[a][c] = 1'b1;
                                if (bypass_sel) begin
                                        exp_out[a][c] = ext_beat;
                                end else if (test_mode_en && run_now) begin
                                        exp_out[a][c]  = mdl_play;
                                        exp_full[a][c] = mdl_play.valid;
                                end else begin
                                        exp_out[a][c] = dfe_in[a][c];
                                end
                        end
                        exp_td[a] = mdl_play;
                end
                mdl_play.valid = rd_now;
                if (rd_now) begin
                        mdl_play.user = ref_mem[mdl_addr].user;
                        mdl_play.data = ref_mem[mdl_addr].data;
                end
                // zero or oversized length plays the whole buffer
                len_i = int'(play_len);
                if (len_i == 0 || len_i > BUF_DEPTH) begin
                        len_i = BUF_DEPTH;
                end
                // wrap pulses only when the last word of the loop is read
                exp_wrap = 1'b0;
                if (restart_now) begin
                        mdl_addr = 0;
                end else if (rd_now) begin
                        if (mdl_addr == len_i - 1) begin
                                mdl_addr = 0;
                                exp_wrap = 1'b1;
                        end else begin
                                mdl_addr = (mdl_addr + 1) % BUF_DEPTH;
                        end
                end
                if (!test_mode_en) begin
                        mdl_state = PLAY_IDLE;
                end else if (mdl_state == PLAY_IDLE) begin
                        mdl_state = PLAY_WAIT_FRAME;
                end else if (mdl_state == PLAY_WAIT_FRAME && frm_mrkr) begin
                        mdl_state = PLAY_RUN;
                end
        endtask

        task automatic apply_cycle(input logic byp, input logic tm, input logic [LEN_W-1:0] len,
                        input logic x1, input logic frm, input logic lden,
                        input logic [ADDR_W-1:0] laddr, input wave_word_t lword, input logic live);
                int     a;
                int     c;
                integer rnd;
                @(posedge clk_1x);
                #2;
                // outputs settled at the edge
                check_outputs();
                bypass_sel   = byp;
                test_mode_en = tm;
                play_len     = len;
                clk_x1en     = x1;
                frm_mrkr     = frm;
                load_en      = lden;
                load_addr    = laddr;
                load_word    = lword;
                // fresh stream data every cycle, valid is random when live
                for (a = 0; a < N_ANTS_SEL; a++) begin
                        for (c = 0; c < N_CARRIERS; c++) begin
                                rnd = $random(seed);
                                dfe_in[a][c].valid = live && rnd[0];
                                dfe_in[a][c].user  = rnd[2:1];
                                dfe_in[a][c].data  = $random(seed);
                        end
                end
                rnd = $random(seed);
                ext_beat.valid = live && rnd[0];
                ext_beat.user  = rnd[2:1];
                ext_beat.data  = $random(seed);
                model_update();
        endtask

        task automatic build_table();
                // bypass, test mode, length, cycles, quarter x1en, frame at
                rows[0]  = '{1'b0, 1'b0, LEN_W'(0),  8'd24, 1'b0, 8'(NO_FRM)};
                rows[1]  = '{1'b1, 1'b0, LEN_W'(0),  8'd20, 1'b0, 8'(NO_FRM)};
                rows[2]  = '{1'b1, 1'b1, LEN_W'(0),  8'd20, 1'b0, 8'(NO_FRM)};
                // full buffer with wrap, then short loops
                rows[3]  = '{1'b0, 1'b1, LEN_W'(0),  8'd90, 1'b0, 8'd10};
                rows[4]  = '{1'b0, 1'b1, LEN_W'(10), 8'd50, 1'b1, 8'd3};
                rows[5]  = '{1'b0, 1'b1, LEN_W'(10), 8'd40, 1'b0, 8'd15};
                rows[6]  = '{1'b0, 1'b0, LEN_W'(10), 8'd20, 1'b0, 8'(NO_FRM)};
                // re-arm waits for a new marker
                rows[7]  = '{1'b0, 1'b1, LEN_W'(7),  8'd30, 1'b1, 8'(NO_FRM)};
                rows[8]  = '{1'b0, 1'b1, LEN_W'(7),  8'd40, 1'b0, 8'd2};
                rows[9]  = '{1'b1, 1'b1, LEN_W'(7),  8'd15, 1'b0, 8'(NO_FRM)};
                rows[10] = '{1'b0, 1'b0, LEN_W'(0),  8'd10, 1'b0, 8'(NO_FRM)};
        endtask

        initial begin
                int         r;
                int         k;
                int         i;
                integer     rnd;
                wave_word_t word;
                build_table();
                for (r = 0; r < N_ROWS; r++) begin
                        cycle_limit += int'(rows[r].cycles);
                end
                clk_1x       = 1'b0;
                rst_n        = 1'b0;
                clk_x1en     = 1'b0;
                frm_mrkr     = 1'b0;
                bypass_sel   = 1'b0;
                test_mode_en = 1'b0;
                play_len     = '0;
                load_en      = 1'b0;
                load_addr    = '0;
                load_word    = '0;
                ext_beat     = '0;
                dfe_in       = '0;
                mdl_state    = PLAY_IDLE;
                mdl_addr     = 0;
                mdl_play     = '0;
                exp_wrap     = 1'b0;
                for (i = 0; i < N_ANTS_SEL * N_CARRIERS; i++) begin
                        exp_out[i / N_CARRIERS][i % N_CARRIERS]  = '0;
                        exp_full[i / N_CARRIERS][i % N_CARRIERS] = 1'b0;
                        exp_td[i / N_CARRIERS] = '0;
                end
                repeat (16) @(posedge clk_1x);
                #2;
                rst_n = 1'b1;
                // nothing valid straight out of reset
                check_outputs();
                model_update();
                // fill the wave buffer with streams held quiet
                for (i = 0; i < BUF_DEPTH; i++) begin
                        rnd       = $random(seed);
                        word.user = rnd[1:0];
                        word.data = $random(seed);
                        ref_mem[i] = word;
                        apply_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b1, ADDR_W'(i), word, 1'b0);
                end
                for (r = 0; r < N_ROWS; r++) begin
                        for (k = 0; k < int'(rows[r].cycles); k++) begin
                                apply_cycle(rows[r].bypass_sel, rows[r].test_mode_en,
                                        rows[r].play_len, !rows[r].x1en_quarter || (k % 4 == 0),
                                        k == int'(rows[r].frm_at), 1'b0, '0, '0, 1'b1);
                        end
                end
                // flush the last beats out of the output registers
                repeat (2) apply_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0, 1'b0);
                $display("checked %0d values", n_checks);
                $display("all tests passed");
                $finish;
        end

endmodule

// ==== sources.f ====
logic/fhbuf_pkg.sv
logic/wave_buffer.sv
logic/play_counter.sv
logic/play_fsm.sv
logic/path_select.sv
logic/fhbuf_top.sv
tests/fhbuf_properties.sv
tests/fhbuf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fronthaul test buffer simulation with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
        --top-module fhbuf_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/Vfhbuf_tb > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
        echo "RESULT: FAIL"
        exit 1
fi
if [ $run_status -ne 0 ]; then
        echo "RESULT: FAIL (simulator exit status $run_status)"
        exit 1
fi
echo "RESULT: PASS"
exit 0
